//--- sim/sifhCases.mem
// header: frame count, pixel count; per frame: idle, coarse and fine sections (count, events)
// then one expected word per pixel; event {pixel, coarse, fine}, expected {pixel, coarse, fine}
0002 0008
// frame 1 idle
0000
// frame 1 coarse, tie on pixel 4, bursts on pixel 2 decided by one
0012
0140 0151 0140 0240 1500 1501
22C0 22C0 2280 2280 2280
4780 41C0 4780 41C0 5FC0 6040 7A00
// frame 1 fine, heavy off-peak hits on pixels 0 1 2 3 7
0018
0272 0272 0272 0272 014C 014C 015E
1542 1542 1542 1521 1507
22AC 22AC 22AC 22AD 22AD 22ED 22ED
3049 41D4 5FFF 6042 7A45
014C 1507 22AC 3000 41D4 5FFF 6042 7A00
// frame 2 idle events, then data that a stale histogram would override
0003 0C80 0C80 0C80
0002 0240 22C0
0003 0243 22ED 1005
0243 1005 22ED 3000 4000 5000 6000 7000

//--- flist.f
common/sifhPkg.sv
histogram/binMapper.sv
histogram/histAccumulator.sv
rtl/histSequencer.sv
rtl/peakDetector.sv
rtl/sifhTop.sv
sim/clockGen.sv
sim/sifhTb.sv

//--- Makefile
# Verilator flow for the histogram ranging block

OBJ = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module sifhTb

sim:
	verilator --binary --timing --assert -f flist.f --top-module sifhTb -Mdir $(OBJ) -o sifhSim
	./$(OBJ)/sifhSim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

//--- sim/sifhTb.sv
`timescale 1ns/100ps

module sifhTb;
    import sifhPkg::*;

    localparam int NumPixels = 8;
    localparam int NumBins = 2**NumBinBits;
    localparam int CaseWords = 256;
    // drain, coarse sweep and peak write-back, with some slack
    localparam int CoarseWait = 3 + NumPixels * NumBins + 8;
    localparam int ModeIdle = 0;
    localparam int ModeCoarse = 1;
    localparam int ModeFine = 2;

    logic clk;
    logic reset;
    logic start;
    tdcEvent evt;
    logic eventValid;
    logic acqEnd;
    peakResult result;
    logic resultValid;
    logic frameDone;
    logic busy;

    logic [15:0] caseMem [CaseWords];
    int ptr;
    int errors;
    int testsRun;
    int testsFailed;
    int cycles;
    int cycleLimit;
    int lastResultCycle;
    // results captured in the current frame
    peakResult seen [$];
    logic frameActive;
    logic doneSeen;

    // reference histograms built from the same events
    int coarseHist [NumPixels][NumBins];
    int fineHist [NumPixels][NumBins];
    int coarseRef [NumPixels];

    clockGen uClock (.clk(clk), .reset(reset));

    sifhTop #(.NumPixels(NumPixels)) i_dut (
        .clk(clk),
        .reset(reset),
        .start(start),
        .evt(evt),
        .eventValid(eventValid),
        .acqEnd(acqEnd),
        .result(result),
        .resultValid(resultValid),
        .frameDone(frameDone),
        .busy(busy)
    );

    task automatic checkValue(input int got, input int want, input string what);
        if (got !== want) begin
            $display("error at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
            errors++;
        end
    endtask

    // lowest bin with the strictly largest count, bin 0 when empty
    function automatic int peakOf(input int pix, input bit fine);
        int best;
        int bestCount;
        int c;
        int b;
        best = 0;
        bestCount = -1;
        for (b = 0; b < NumBins; b++) begin
            c = fine ? fineHist[pix][b] : coarseHist[pix][b];
            if (c > bestCount) begin
                best = b;
                bestCount = c;
            end
        end
        return best;
    endfunction

    // total events in the case file, for the timeout
    function automatic int countEvents(input int frames);
        int q;
        int total;
        int f;
        int s;
        q = 2;
        total = 0;
        for (f = 0; f < frames; f++) begin
            // idle, coarse and fine sections
            for (s = 0; s < 3; s++) begin
                total += int'(caseMem[q]);
                q += int'(caseMem[q]) + 1;
            end
            q += NumPixels;
        end
        return total;
    endfunction

    task automatic clearModel();
        int p;
        int b;
        for (p = 0; p < NumPixels; p++) begin
            coarseRef[p] = 0;
            for (b = 0; b < NumBins; b++) begin
                coarseHist[p][b] = 0;
                fineHist[p][b] = 0;
            end
        end
    endtask

    // one event per cycle, back to back
    task automatic sendEvents(input int mode);
        int count;
        int i;
        int w;
        int p;
        int c;
        count = int'(caseMem[ptr]);
        ptr++;
        for (i = 0; i < count; i++) begin
            w = int'(caseMem[ptr]);
            ptr++;
            p = w >> 12;
            c = (w >> 6) & 63;
            evt = tdcEvent'(w[15:0]);
            eventValid = 1'b1;
            if (p < NumPixels && mode == ModeCoarse) begin
                coarseHist[p][c]++;
            end else if (p < NumPixels && mode == ModeFine && c == coarseRef[p]) begin
                // fine hits only inside the pixel's coarse peak
                fineHist[p][w & 63]++;
            end
            @(posedge clk);
            #1;
        end
        eventValid = 1'b0;
    endtask

    task automatic endAcquisition();
        acqEnd = 1'b1;
        @(posedge clk);
        #1;
        acqEnd = 1'b0;
    endtask

    task automatic runFrame(input int frame);
        int errorsBefore;
        int p;
        int want;
        errorsBefore = errors;
        clearModel();
        // the DUT is idle here, these must be dropped
        sendEvents(ModeIdle);
        seen.delete();
        doneSeen = 1'b0;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        frameActive = 1'b1;
        sendEvents(ModeCoarse);
        endAcquisition();
        for (p = 0; p < NumPixels; p++) begin
            coarseRef[p] = peakOf(p, 1'b0);
        end
        repeat (CoarseWait) @(posedge clk);
        #1;
        sendEvents(ModeFine);
        endAcquisition();
        while (!doneSeen) @(negedge clk);
        @(posedge clk);
        #1;
        frameActive = 1'b0;
        for (p = 0; p < NumPixels; p++) begin
            want = (p << 12) | (coarseRef[p] << 6) | peakOf(p, 1'b1);
            checkValue(want, int'(caseMem[ptr]), $sformatf("model vs case file, pixel %0d", p));
            if (p < seen.size()) begin
                checkValue(int'(seen[p]), want, $sformatf("result of pixel %0d", p));
            end
            ptr++;
        end
        testsRun++;
        if (errors != errorsBefore) begin
            testsFailed++;
        end
        $display("frame %0d: %s", frame, (errors == errorsBefore) ? "ok" : "mismatch");
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (resultValid) begin
            seen.push_back(result);
            lastResultCycle = cycles;
        end
        if (frameDone) begin
            checkValue(cycles - lastResultCycle, 1, "frameDone delay after last result");
            checkValue(seen.size(), NumPixels, "results before frameDone");
            doneSeen = 1'b1;
        end
        if (frameActive && !doneSeen) begin
            checkValue(int'(busy), 1, "busy during frame");
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles > cycleLimit) begin
            $display("timeout: frame did not complete within %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        int frames;
        int f;
        start = 1'b0;
        evt = '0;
        eventValid = 1'b0;
        acqEnd = 1'b0;
        errors = 0;
        testsRun = 0;
        testsFailed = 0;
        cycles = 0;
        cycleLimit = 0;
        lastResultCycle = 0;
        frameActive = 1'b0;
        doneSeen = 1'b0;
        $readmemh("sim/sifhCases.mem", caseMem);
        frames = int'(caseMem[0]);
        if (frames == 0) begin
            $display("case file missing or holds no frames");
            errors++;
        end
        checkValue(int'(caseMem[1]), NumPixels, "pixel count in case file");
        cycleLimit = 2 * (frames * (2 * NumPixels * NumBins + countEvents(frames) + 20));
        ptr = 2;
        // clearing sweep runs on its own after reset
        wait (reset);
        while (!busy) @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        #1;
        for (f = 1; f <= frames; f++) begin
            runFrame(f);
        end
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- sim/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // active low, released just after a rising edge
    initial begin
        reset = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        #1 reset = 1'b1;
    end

endmodule

//--- rtl/sifhTop.sv
`timescale 1ns/100ps

module sifhTop #(
    parameter int NumPixels = 8
) (
    input logic clk,
    input logic reset,
    input logic start,
    input sifhPkg::tdcEvent evt,
    input logic eventValid,
    input logic acqEnd,
    output sifhPkg::peakResult result,
    output logic resultValid,
    output logic frameDone,
    output logic busy
);
    import sifhPkg::*;

    // sequencer outputs
    seqState phase;
    sweepRead rd;
    logic rdValid;

    // mapper to histogram
    binRef incAddr;
    logic incValid;

    // histogram to detector
    binSample sample;
    logic sampleValid;

    // detector feedback
    logic peakValid;
    pixelId peakPixel;
    binAddr peakBin;
    logic sweepDone;

    histSequencer #(.NumPixels(NumPixels)) uSequencer (
        .clk(clk),
        .reset(reset),
        .start(start),
        .acqEnd(acqEnd),
        .sweepDone(sweepDone),
        .phase(phase),
        .rd(rd),
        .rdValid(rdValid),
        .busy(busy),
        .frameDone(frameDone)
    );

    binMapper uMapper (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .evt(evt),
        .eventValid(eventValid),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .incAddr(incAddr),
        .incValid(incValid)
    );

    histAccumulator #(.NumPixels(NumPixels)) uHistogram (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .incAddr(incAddr),
        .incValid(incValid),
        .rd(rd),
        .rdValid(rdValid),
        .sample(sample),
        .sampleValid(sampleValid)
    );

    peakDetector #(.NumPixels(NumPixels)) uPeak (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .sample(sample),
        .sampleValid(sampleValid),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .result(result),
        .resultValid(resultValid),
        .sweepDone(sweepDone)
    );

endmodule

//--- rtl/peakDetector.sv
`timescale 1ns/100ps

module peakDetector #(
    parameter int NumPixels = 8
) (
    input logic clk,
    input logic reset,
    input sifhPkg::seqState phase,
    input sifhPkg::binSample sample,
    input logic sampleValid,
    output logic peakValid,
    output sifhPkg::pixelId peakPixel,
    output sifhPkg::binAddr peakBin,
    output sifhPkg::peakResult result,
    output logic resultValid,
    output logic sweepDone
);
    import sifhPkg::*;

    // running maximum and where it was seen
    binCount runMax;
    binAddr runBin;
    logic takeNew;
    binCount nextMax;
    binAddr nextBin;
    logic pixelEnd;
    logic inFine;

    // fine-pass pixel count
    pixelId pixCount;
    logic finalPixel;
    // local copy of coarse peaks for the result
    binAddr coarseCopy [2**NumPixelBits];

    // bin 0 restarts the search, strict compare keeps the lower bin on ties
    assign takeNew = (sample.bin == '0) || (sample.count > runMax);
    assign nextMax = takeNew ? sample.count : runMax;
    assign nextBin = takeNew ? sample.bin : runBin;
    assign pixelEnd = sampleValid && sample.lastBin;
    assign inFine = (phase == fineSweep);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            peakValid <= 1'b0;
            resultValid <= 1'b0;
            sweepDone <= 1'b0;
            pixCount <= '0;
            finalPixel <= 1'b0;
        end else begin
            peakValid <= pixelEnd;
            resultValid <= pixelEnd && inFine;
            // one cycle after the last result
            sweepDone <= resultValid && finalPixel;
            if (pixelEnd && inFine) begin
                if (pixCount == pixelId'(NumPixels - 1)) begin
                    pixCount <= '0;
                    finalPixel <= 1'b1;
                end else begin
                    pixCount <= pixCount + pixelId'(1);
                    finalPixel <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sampleValid) begin
            runMax <= nextMax;
            runBin <= nextBin;
        end
        if (pixelEnd) begin
            peakPixel <= sample.pixel;
            peakBin <= nextBin;
        end
        if (pixelEnd && phase == coarseSweep) begin
            coarseCopy[sample.pixel] <= nextBin;
        end
        if (pixelEnd && inFine) begin
            result <= '{pixel: sample.pixel, coarsePeak: coarseCopy[sample.pixel],
                        finePeak: nextBin};
        end
    end

endmodule

//--- rtl/histSequencer.sv
`timescale 1ns/100ps

module histSequencer #(
    parameter int NumPixels = 8
) (
    input logic clk,
    input logic reset,
    input logic start,
    input logic acqEnd,
    input logic sweepDone,
    output sifhPkg::seqState phase,
    output sifhPkg::sweepRead rd,
    output logic rdValid,
    output logic busy,
    output logic frameDone
);
    import sifhPkg::*;

    seqState state;
    // histogram memory holds garbage after reset, one sweep clears it
    logic clearPending;
    // drain length, reused for the coarse sweep tail
    logic [1:0] drainCnt;
    pixelId sweepPixel;
    binAddr sweepBin;
    // high while sweep reads are going out
    logic issuing;
    logic lastRead;

    assign lastRead = (sweepBin == '1) && (sweepPixel == pixelId'(NumPixels - 1));

    assign phase = state;
    assign rd = '{pixel: sweepPixel, bin: sweepBin, lastBin: (sweepBin == '1)};
    assign rdValid = issuing;
    // also high during the clearing sweep after reset
    assign busy = (state != idle);
    assign frameDone = (state == fineSweep) && !issuing && sweepDone;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= idle;
            clearPending <= 1'b1;
            drainCnt <= '0;
            sweepPixel <= '0;
            sweepBin <= '0;
            issuing <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (clearPending) begin
                        // blank coarse sweep, peaks thrown away
                        state <= coarseSweep;
                        issuing <= 1'b1;
                        sweepPixel <= '0;
                        sweepBin <= '0;
                    end else if (start) begin
                        state <= coarseAcq;
                    end
                end
                coarseAcq: begin
                    if (acqEnd) begin
                        state <= coarseDrain;
                        drainCnt <= '0;
                    end
                end
                fineAcq: begin
                    if (acqEnd) begin
                        state <= fineDrain;
                        drainCnt <= '0;
                    end
                end
                coarseDrain, fineDrain: begin
                    // let the last increments reach memory
                    drainCnt <= drainCnt + 2'd1;
                    if (drainCnt == 2'd2) begin
                        state <= (state == coarseDrain) ? coarseSweep : fineSweep;
                        issuing <= 1'b1;
                        sweepPixel <= '0;
                        sweepBin <= '0;
                    end
                end
                coarseSweep, fineSweep: begin
                    if (issuing) begin
                        sweepBin <= sweepBin + binAddr'(1);
                        if (sweepBin == '1) begin
                            sweepPixel <= sweepPixel + pixelId'(1);
                        end
                        if (lastRead) begin
                            issuing <= 1'b0;
                            drainCnt <= '0;
                        end
                    end else if (state == coarseSweep) begin
                        // wait for the last peak to land in the mapper
                        drainCnt <= drainCnt + 2'd1;
                        if (drainCnt == 2'd1) begin
                            state <= clearPending ? idle : fineAcq;
                            clearPending <= 1'b0;
                        end
                    end else if (sweepDone) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // reads only go out while a sweep is running
    rdOnlyInSweep: assert property (@(posedge clk) disable iff (!reset)
        rdValid |-> (phase == coarseSweep || phase == fineSweep));

endmodule

//--- histogram/histAccumulator.sv
`timescale 1ns/100ps

module histAccumulator #(
    parameter int NumPixels = 8
) (
    input logic clk,
    input logic reset,
    input sifhPkg::seqState phase,
    input sifhPkg::binRef incAddr,
    input logic incValid,
    input sifhPkg::sweepRead rd,
    input logic rdValid,
    output sifhPkg::binSample sample,
    output logic sampleValid
);
    import sifhPkg::*;

    localparam int Depth = NumPixels * (2**NumBinBits);
    localparam int WordBits = $clog2(Depth);

    // pixel-major counter array
    binCount mem [Depth];

    logic sweepTake;
    logic incTake;
    logic [WordBits-1:0] readWord;
    // shared read port output
    binCount memQ;

    // stage 1 of the increment
    logic s1Valid;
    logic [WordBits-1:0] s1Word;
    // last write, kept for forwarding
    logic wrValid;
    logic [WordBits-1:0] wrWord;
    binCount wrCount;

    // sweep read held for one cycle
    sweepRead rdQ;
    logic rdQValid;

    binCount base;
    binCount incCount;

    assign sweepTake = rdValid && (phase == coarseSweep || phase == fineSweep);
    // pixels beyond the array are dropped
    assign incTake = incValid && !sweepTake && (int'(incAddr.pixel) < NumPixels);

    // one read port, sweep has priority
    assign readWord = sweepTake ? WordBits'({rd.pixel, rd.bin}) : WordBits'(incAddr);

    // previous write not yet visible in memQ on back-to-back hits
    assign base = (wrValid && wrWord == s1Word) ? wrCount : memQ;
    // hold at full scale
    assign incCount = (base == '1) ? base : base + binCount'(1);

    always_ff @(posedge clk) begin
        memQ <= mem[readWord];
        if (s1Valid) begin
            mem[s1Word] <= incCount;
        end else if (sweepTake) begin
            // clear on read
            mem[readWord] <= '0;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            s1Valid <= 1'b0;
            wrValid <= 1'b0;
            rdQValid <= 1'b0;
        end else begin
            s1Valid <= incTake;
            wrValid <= s1Valid;
            rdQValid <= sweepTake;
        end
    end

    always_ff @(posedge clk) begin
        s1Word <= readWord;
        wrWord <= s1Word;
        wrCount <= incCount;
        rdQ <= rd;
    end

    assign sample = '{pixel: rdQ.pixel, bin: rdQ.bin, count: memQ, lastBin: rdQ.lastBin};
    assign sampleValid = rdQValid;

    // sweep reads never meet an increment in flight
    noIncDuringSweep: assert property (@(posedge clk) disable iff (!reset)
        rdValid |-> !incValid && !$past(incValid));

endmodule

//--- histogram/binMapper.sv
`timescale 1ns/100ps

module binMapper (
    input logic clk,
    input logic reset,
    input sifhPkg::seqState phase,
    input sifhPkg::tdcEvent evt,
    input logic eventValid,
    input logic peakValid,
    input sifhPkg::pixelId peakPixel,
    input sifhPkg::binAddr peakBin,
    output sifhPkg::binRef incAddr,
    output logic incValid
);
    import sifhPkg::*;

    // coarse peak per pixel, full pixelId range
    binAddr coarsePeak [2**NumPixelBits];

    binAddr evCoarse;
    binAddr evFine;
    logic keep;
    binAddr mappedBin;

    // split the time code
    assign evCoarse = evt.code[NumTimeBits-1 -: NumBinBits];
    assign evFine = evt.code[NumBinBits-1:0];

    always_comb begin
        keep = 1'b0;
        mappedBin = evCoarse;
        case (phase)
            coarseAcq: begin
                keep = eventValid;
                mappedBin = evCoarse;
            end
            fineAcq: begin
                // only events inside this pixel's coarse peak
                keep = eventValid && (evCoarse == coarsePeak[evt.pixel]);
                mappedBin = evFine;
            end
            default: begin
                // events dropped outside acquisition
                keep = 1'b0;
                mappedBin = evCoarse;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            incValid <= 1'b0;
        end else begin
            incValid <= keep;
        end
    end

    always_ff @(posedge clk) begin
        incAddr <= '{pixel: evt.pixel, bin: mappedBin};
        // coarse peaks come back during the coarse sweep
        if (peakValid && phase == coarseSweep) begin
            coarsePeak[peakPixel] <= peakBin;
        end
    end

    // increments trail their event by one cycle and may land in drain
    incOnlyFromAcq: assert property (@(posedge clk) disable iff (!reset)
        incValid |-> (phase == coarseAcq || phase == coarseDrain ||
                      phase == fineAcq || phase == fineDrain));

endmodule

//--- common/sifhPkg.sv
package sifhPkg;

    // fixed field widths
    localparam int NumBinBits = 6;
    localparam int NumTimeBits = 2 * NumBinBits;
    localparam int NumPixelBits = 4;
    localparam int NumCountBits = 12;

    // bin index inside one pixel histogram
    typedef logic [NumBinBits-1:0] binAddr;
    // full time code, coarse bin on top, fine bin below
    typedef logic [NumTimeBits-1:0] timeCode;
    typedef logic [NumPixelBits-1:0] pixelId;
    // saturating histogram counter
    typedef logic [NumCountBits-1:0] binCount;

    // frame phases
    typedef enum logic [2:0] {
        idle,
        coarseAcq,
        coarseDrain,
        coarseSweep,
        fineAcq,
        fineDrain,
        fineSweep
    } seqState;

    typedef struct packed {
        pixelId pixel;
        timeCode code;
    } tdcEvent;

    // one histogram word, pixel major
    typedef struct packed {
        pixelId pixel;
        binAddr bin;
    } binRef;

    typedef struct packed {
        pixelId pixel;
        binAddr bin;
        logic lastBin;
    } sweepRead;

    typedef struct packed {
        pixelId pixel;
        binAddr bin;
        binCount count;
        logic lastBin;
    } binSample;

    typedef struct packed {
        pixelId pixel;
        binAddr coarsePeak;
        binAddr finePeak;
    } peakResult;

endpackage
